// ==== hdl/board_io_pkg.sv ====
// Board I/O shared definitions
// Address map, bus and display widths, UART timing, select and state enums
package board_io_pkg;

	localparam int addr_w = 32;	// I/O address width
	localparam int data_w = 32;	// I/O data width
	localparam int red_w = 18;	// Red LED bank
	localparam int green_w = 9;	// Green LED bank
	localparam int hex_w = 7;	// One seven-segment digit

	localparam logic [addr_w-1:0] addr_red = 32'h00;
	localparam logic [addr_w-1:0] addr_green = 32'h04;
	localparam logic [addr_w-1:0] addr_hex0 = 32'h08;
	localparam logic [addr_w-1:0] addr_hex1 = 32'h0c;
	localparam logic [addr_w-1:0] addr_hex2 = 32'h10;
	localparam logic [addr_w-1:0] addr_hex3 = 32'h14;
	localparam logic [addr_w-1:0] addr_uart_status = 32'h18;
	localparam logic [addr_w-1:0] addr_uart_data = 32'h1c;
	localparam logic [addr_w-1:0] addr_timer = 32'h24;	// 0x20 left unmapped

	localparam int baud_divide = 27;	// clk50 cycles per bit
	localparam int uart_bits = 8;	// Data bits per frame
	localparam int baud_cnt_w = $clog2(baud_divide);
	localparam int bit_cnt_w = $clog2(uart_bits);
	localparam logic [baud_cnt_w-1:0] baud_last = baud_cnt_w'(baud_divide - 1);
	localparam logic [baud_cnt_w-1:0] baud_half = baud_cnt_w'(baud_divide / 2);
	localparam logic [bit_cnt_w-1:0] bit_last = bit_cnt_w'(uart_bits - 1);

	typedef enum logic [3:0]
	{
		sel_red, sel_green, sel_hex0, sel_hex1, sel_hex2, sel_hex3,
		sel_uart_status, sel_uart_data, sel_timer, sel_none
	} io_sel_e;	// Target of a bus cycle

	typedef enum logic [1:0]
	{
		st_idle, st_start, st_data, st_stop
	} uart_state_e;	// Shared by TX and RX machines

endpackage

// ==== hdl/io_bus_if.sv ====
// Decoded I/O bus between the address decoder and the register targets
`timescale 1ns/1ps

interface io_bus_if;

	logic write_en;	// Single-cycle write strobe
	logic read_en;	// Read strobe, only consumes UART data
	logic [board_io_pkg::data_w-1:0] write_data;
	board_io_pkg::io_sel_e sel;	// Register picked by the address

	modport decoder
	(
		output write_en, read_en, write_data, sel
	);

	modport target
	(
		input write_en, read_en, write_data, sel
	);

endinterface

// ==== hdl/io_addr_decode.sv ====
// Address decoder
// Maps the raw I/O address onto one register select, forwards strobes and data
`timescale 1ns/1ps

module io_addr_decode
(
	input logic io_write_en,
	input logic io_read_en,
	input logic [board_io_pkg::addr_w-1:0] io_address,
	input logic [board_io_pkg::data_w-1:0] io_write_data,
	io_bus_if.decoder bus
);

	// Strobes and payload pass straight through
	assign bus.write_en = io_write_en;
	assign bus.read_en = io_read_en;
	assign bus.write_data = io_write_data;

	// Exact match only, so unaligned addresses fall to sel_none
	always_comb
	begin
		case (io_address)
			board_io_pkg::addr_red: bus.sel = board_io_pkg::sel_red;
			board_io_pkg::addr_green: bus.sel = board_io_pkg::sel_green;
			board_io_pkg::addr_hex0: bus.sel = board_io_pkg::sel_hex0;
			board_io_pkg::addr_hex1: bus.sel = board_io_pkg::sel_hex1;
			board_io_pkg::addr_hex2: bus.sel = board_io_pkg::sel_hex2;
			board_io_pkg::addr_hex3: bus.sel = board_io_pkg::sel_hex3;
			board_io_pkg::addr_uart_status: bus.sel = board_io_pkg::sel_uart_status;
			board_io_pkg::addr_uart_data: bus.sel = board_io_pkg::sel_uart_data;
			board_io_pkg::addr_timer: bus.sel = board_io_pkg::sel_timer;
			default: bus.sel = board_io_pkg::sel_none;	// Unmapped hole
		endcase
	end

endmodule

// ==== hdl/display_regs.sv ====
// Display registers
// Red and green LED banks plus four seven-segment digits, written from the bus
`timescale 1ns/1ps

module display_regs
(
	input logic clk50,
	input logic core_reset,
	io_bus_if.target bus,
	output logic [board_io_pkg::red_w-1:0] red_led,
	output logic [board_io_pkg::green_w-1:0] green_led,
	output logic [board_io_pkg::hex_w-1:0] hex0,
	output logic [board_io_pkg::hex_w-1:0] hex1,
	output logic [board_io_pkg::hex_w-1:0] hex2,
	output logic [board_io_pkg::hex_w-1:0] hex3
);

	always_ff @(posedge clk50, posedge core_reset)
	begin
		if (core_reset)
		begin
			red_led <= '0;	// All segments and LEDs dark
			green_led <= '0;
			hex0 <= '0;
			hex1 <= '0;
			hex2 <= '0;
			hex3 <= '0;
		end
		else if (bus.write_en)
		begin
			// Low bits only, upper data bits dropped
			case (bus.sel)
				board_io_pkg::sel_red: red_led <= bus.write_data[board_io_pkg::red_w-1:0];
				board_io_pkg::sel_green: green_led <= bus.write_data[board_io_pkg::green_w-1:0];
				board_io_pkg::sel_hex0: hex0 <= bus.write_data[board_io_pkg::hex_w-1:0];
				board_io_pkg::sel_hex1: hex1 <= bus.write_data[board_io_pkg::hex_w-1:0];
				board_io_pkg::sel_hex2: hex2 <= bus.write_data[board_io_pkg::hex_w-1:0];
				board_io_pkg::sel_hex3: hex3 <= bus.write_data[board_io_pkg::hex_w-1:0];
				default: ;	// Other targets live elsewhere
			endcase
		end
	end

endmodule

// ==== hdl/uart_port.sv ====
// UART port
// Transmit FSM with shifter, receive FSM with synchronizer and one-byte buffer,
// status word for the readback mux
`timescale 1ns/1ps

module uart_port
(
	input logic clk50,
	input logic core_reset,
	io_bus_if.target bus,
	input logic uart_rx,
	output logic uart_tx,
	output logic [board_io_pkg::data_w-1:0] uart_status,
	output logic [board_io_pkg::data_w-1:0] uart_rx_data
);

	board_io_pkg::uart_state_e tx_state;
	logic [board_io_pkg::baud_cnt_w-1:0] tx_cnt;	// Cycles within current bit
	logic [board_io_pkg::bit_cnt_w-1:0] tx_bit;	// Data bit index
	logic [board_io_pkg::uart_bits-1:0] tx_shift;	// LSB goes out first
	logic tx_load;
	logic tx_bit_end;

	board_io_pkg::uart_state_e rx_state;
	logic [2:0] rx_sync;	// Two sync flops plus one for edge detect
	logic rx_in;
	logic rx_fall;
	logic [board_io_pkg::baud_cnt_w-1:0] rx_cnt;
	logic [board_io_pkg::bit_cnt_w-1:0] rx_bit;
	logic [board_io_pkg::uart_bits-1:0] rx_shift;
	logic [board_io_pkg::uart_bits-1:0] rx_data;	// Last complete byte
	logic rx_avail;
	logic rx_done;

	// Busy writes are dropped, only an idle transmitter loads
	assign tx_load = bus.write_en && bus.sel == board_io_pkg::sel_uart_data
		&& tx_state == board_io_pkg::st_idle;
	assign tx_bit_end = tx_cnt == board_io_pkg::baud_last;

	always_ff @(posedge clk50, posedge core_reset)
	begin
		if (core_reset)
		begin
			tx_state <= board_io_pkg::st_idle;
			tx_cnt <= '0;
			tx_bit <= '0;
		end
		else
		begin
			tx_cnt <= (tx_load || tx_bit_end) ? '0 : tx_cnt + 1'b1;	// Free count while busy
			case (tx_state)
				board_io_pkg::st_idle:
					if (tx_load)
						tx_state <= board_io_pkg::st_start;
				board_io_pkg::st_start:
					if (tx_bit_end)
					begin
						tx_state <= board_io_pkg::st_data;
						tx_bit <= '0;
					end
				board_io_pkg::st_data:
					if (tx_bit_end)
					begin
						tx_bit <= tx_bit + 1'b1;
						if (tx_bit == board_io_pkg::bit_last)
							tx_state <= board_io_pkg::st_stop;
					end
				default:
					if (tx_bit_end)
						tx_state <= board_io_pkg::st_idle;	// Stop bit done
			endcase
		end
	end

	always_ff @(posedge clk50)
	begin
		if (tx_load)
			tx_shift <= bus.write_data[board_io_pkg::uart_bits-1:0];
		else if (tx_state == board_io_pkg::st_data && tx_bit_end)
			tx_shift <= tx_shift >> 1;	// Next bit to LSB
	end

	always_comb
	begin
		case (tx_state)
			board_io_pkg::st_start: uart_tx = 1'b0;
			board_io_pkg::st_data: uart_tx = tx_shift[0];
			default: uart_tx = 1'b1;	// Idle and stop both mark
		endcase
	end

	assign rx_in = rx_sync[1];
	assign rx_fall = rx_sync[2] && !rx_sync[1];

	always_ff @(posedge clk50, posedge core_reset)
	begin
		if (core_reset)
		begin
			rx_sync <= 3'b111;	// Line idles high
			rx_state <= board_io_pkg::st_idle;
			rx_cnt <= '0;
			rx_bit <= '0;
		end
		else
		begin
			rx_sync <= {rx_sync[1:0], uart_rx};
			rx_cnt <= rx_cnt + 1'b1;
			case (rx_state)
				board_io_pkg::st_idle:
				begin
					rx_cnt <= '0;
					if (rx_fall)
						rx_state <= board_io_pkg::st_start;
				end
				board_io_pkg::st_start:
					if (rx_cnt == board_io_pkg::baud_half)
					begin
						rx_cnt <= '0;	// Now aligned to bit middle
						rx_bit <= '0;
						rx_state <= rx_in ? board_io_pkg::st_idle : board_io_pkg::st_data;
					end
				board_io_pkg::st_data:
					if (rx_cnt == board_io_pkg::baud_last)
					begin
						rx_cnt <= '0;
						rx_bit <= rx_bit + 1'b1;
						if (rx_bit == board_io_pkg::bit_last)
							rx_state <= board_io_pkg::st_stop;
					end
				default:
					if (rx_done)
						rx_state <= board_io_pkg::st_idle;	// Rearm for next start edge
			endcase
		end
	end

	assign rx_done = rx_state == board_io_pkg::st_stop && rx_cnt == board_io_pkg::baud_last;

	always_ff @(posedge clk50)
	begin
		if (rx_state == board_io_pkg::st_data && rx_cnt == board_io_pkg::baud_last)
			rx_shift <= {rx_in, rx_shift[board_io_pkg::uart_bits-1:1]};	// LSB arrives first
	end

	// Receive buffer, a fresh byte overwrites an unread one
	always_ff @(posedge clk50, posedge core_reset)
	begin
		if (core_reset)
		begin
			rx_data <= '0;
			rx_avail <= 1'b0;
		end
		else if (rx_done)
		begin
			rx_data <= rx_shift;
			rx_avail <= 1'b1;	// Set wins over a same-cycle read
		end
		else if (bus.read_en && bus.sel == board_io_pkg::sel_uart_data)
			rx_avail <= 1'b0;	// Byte consumed
	end

	assign uart_status = {{(board_io_pkg::data_w - 2){1'b0}}, rx_avail,
		tx_state == board_io_pkg::st_idle};
	assign uart_rx_data = {{(board_io_pkg::data_w - board_io_pkg::uart_bits){1'b0}}, rx_data};

endmodule

// ==== hdl/timer_readback.sv ====
// Free-running timer and read data multiplexer
`timescale 1ns/1ps

module timer_readback
(
	input logic clk50,
	input logic core_reset,
	io_bus_if.target bus,
	input logic [board_io_pkg::data_w-1:0] uart_status,
	input logic [board_io_pkg::data_w-1:0] uart_rx_data,
	output logic [board_io_pkg::data_w-1:0] io_read_data
);

	logic [board_io_pkg::data_w-1:0] timer_val;	// Cycle count since reset

	always_ff @(posedge clk50, posedge core_reset)
	begin
		if (core_reset)
			timer_val <= '0;
		else
			timer_val <= timer_val + 1'b1;	// Wraps silently
	end

	// Pure function of the select, no read latency
	always_comb
	begin
		case (bus.sel)
			board_io_pkg::sel_uart_status: io_read_data = uart_status;
			board_io_pkg::sel_uart_data: io_read_data = uart_rx_data;
			board_io_pkg::sel_timer: io_read_data = timer_val;
			default: io_read_data = '0;	// Display regs are write-only
		endcase
	end

endmodule

// ==== hdl/board_io_top.sv ====
// Board I/O peripheral top level
// Decoder, display registers, UART and timer readback on one decoded bus
`timescale 1ns/1ps

module board_io_top
(
	input logic clk50,
	input logic core_reset,
	input logic io_write_en,
	input logic io_read_en,
	input logic [board_io_pkg::addr_w-1:0] io_address,
	input logic [board_io_pkg::data_w-1:0] io_write_data,
	output logic [board_io_pkg::data_w-1:0] io_read_data,
	output logic [board_io_pkg::red_w-1:0] red_led,
	output logic [board_io_pkg::green_w-1:0] green_led,
	output logic [board_io_pkg::hex_w-1:0] hex0,
	output logic [board_io_pkg::hex_w-1:0] hex1,
	output logic [board_io_pkg::hex_w-1:0] hex2,
	output logic [board_io_pkg::hex_w-1:0] hex3,
	output logic uart_tx,
	input logic uart_rx
);

	logic [board_io_pkg::data_w-1:0] uart_status;	// TX idle, RX available
	logic [board_io_pkg::data_w-1:0] uart_rx_data;

	io_bus_if bus();	// Decoded bus shared by all targets

	io_addr_decode decode
	(
		.io_write_en(io_write_en),
		.io_read_en(io_read_en),
		.io_address(io_address),
		.io_write_data(io_write_data),
		.bus(bus.decoder)
	);

	display_regs display
	(
		.clk50(clk50),
		.core_reset(core_reset),
		.bus(bus.target),
		.red_led(red_led),
		.green_led(green_led),
		.hex0(hex0),
		.hex1(hex1),
		.hex2(hex2),
		.hex3(hex3)
	);

	uart_port uart
	(
		.clk50(clk50),
		.core_reset(core_reset),
		.bus(bus.target),
		.uart_rx(uart_rx),
		.uart_tx(uart_tx),
		.uart_status(uart_status),
		.uart_rx_data(uart_rx_data)
	);

	timer_readback readback
	(
		.clk50(clk50),
		.core_reset(core_reset),
		.bus(bus.target),
		.uart_status(uart_status),
		.uart_rx_data(uart_rx_data),
		.io_read_data(io_read_data)
	);

endmodule

// ==== verif/board_io_props.sv ====
// Concurrent assertions on the UART line and receive flag
// and on readback of unmapped addresses, attached with bind
`timescale 1ns/1ps

module board_io_props
(
	input logic clk50,
	input logic core_reset,
	input board_io_pkg::uart_state_e tx_state,
	input board_io_pkg::uart_state_e rx_state,
	input logic uart_tx,
	input logic rx_avail,
	input board_io_pkg::io_sel_e sel,
	input logic [board_io_pkg::data_w-1:0] io_read_data
);

	int fail_count = 0;	// Assertion failures so far

	idle_line_high: assert property (@(posedge clk50) disable iff (core_reset)
		tx_state == board_io_pkg::st_idle |-> uart_tx)
		else
		begin
			$error("uart_tx low while the transmitter is idle");
			fail_count++;
		end

	// Flag is set on the edge that leaves the stop state
	avail_from_stop: assert property (@(posedge clk50) disable iff (core_reset)
		$rose(rx_avail) |-> $past(rx_state) == board_io_pkg::st_stop)
		else
		begin
			$error("receive flag rose outside the stop state");
			fail_count++;
		end

	none_reads_zero: assert property (@(posedge clk50) disable iff (core_reset)
		sel == board_io_pkg::sel_none |-> io_read_data == '0)
		else
		begin
			$error("unmapped address returned nonzero read data");
			fail_count++;
		end

endmodule

// ==== verif/board_io_checker.sv ====
// Result checker for the board I/O testbench
// Display shadow, read data and timer compares, per-test lines and closing counts
`timescale 1ns/1ps

module board_io_checker
(
	input logic clk50,
	input logic core_reset,
	input logic [board_io_pkg::data_w-1:0] io_read_data,
	input logic [board_io_pkg::red_w-1:0] red_led,
	input logic [board_io_pkg::green_w-1:0] green_led,
	input logic [board_io_pkg::hex_w-1:0] hex0, hex1, hex2, hex3,
	input logic uart_tx,
	input logic chk_read, chk_below, chk_mark, chk_delta, chk_display, chk_line_idle,
	input logic wait_timeout, test_done, run_done,
	input int test_num,
	input logic [31:0] exp_addr, exp_value, exp_mask,
	output int error_count, tests_passed, tests_failed
);

	logic [31:0] timer_mark;	// First of two timer reads
	logic [31:0] shadow [6];	// Red, green, hex0 to hex3
	int test_errors;

	task automatic flag_error(input string msg);
		$display("[ERROR] %0t: %s", $time, msg);
		test_errors++;
		error_count++;
	endtask

	task automatic compare(input string what, input logic [31:0] got, input logic [31:0] want);
		if (got !== want)
			flag_error($sformatf("%s is 0x%08h, expected 0x%08h", what, got, want));
	endtask

	// Samples on the edge, values settled in the cycle before
	always @(posedge clk50)
	begin
		if (core_reset)
		begin
			error_count = 0;
			tests_passed = 0;
			tests_failed = 0;
			test_errors = 0;
			for (int k = 0; k < 6; k++)
				shadow[k] = '0;	// Outputs clear in reset
		end
		else
		begin
			if (chk_read)
				compare("read data", io_read_data & exp_mask, exp_value);
			if (chk_below && io_read_data >= exp_value)
				flag_error($sformatf("timer read %0d, expected below %0d", io_read_data, exp_value));
			if (chk_mark)
				timer_mark = io_read_data;
			if (chk_delta)
				compare("timer step", io_read_data - timer_mark, exp_value);
			if (chk_line_idle)
				compare("uart_tx", 32'(uart_tx), 32'd1);
			if (chk_display)
			begin
				case (exp_addr)	// Unmapped writes leave the shadow alone
					board_io_pkg::addr_red: shadow[0] = exp_value;
					board_io_pkg::addr_green: shadow[1] = exp_value;
					board_io_pkg::addr_hex0: shadow[2] = exp_value;
					board_io_pkg::addr_hex1: shadow[3] = exp_value;
					board_io_pkg::addr_hex2: shadow[4] = exp_value;
					board_io_pkg::addr_hex3: shadow[5] = exp_value;
					default: ;
				endcase
				compare("red_led", 32'(red_led), shadow[0]);
				compare("green_led", 32'(green_led), shadow[1]);
				compare("hex0", 32'(hex0), shadow[2]);
				compare("hex1", 32'(hex1), shadow[3]);
				compare("hex2", 32'(hex2), shadow[4]);
				compare("hex3", 32'(hex3), shadow[5]);
			end
			if (wait_timeout)
			begin
				$display("Test %0d: UART status bit did not change within 300 cycles", test_num);
				test_errors++;
				error_count++;
			end
			if (test_done)
			begin
				if (test_errors == 0)
				begin
					tests_passed++;
					$display("Test %0d passed", test_num);
				end
				else
				begin
					tests_failed++;
					$display("Test %0d failed with %0d errors", test_num, test_errors);
				end
				test_errors = 0;	// Fresh count per test
			end
			if (run_done)
				$display("Tests passed %0d, failed %0d, errors %0d", tests_passed,
					tests_failed, error_count);
		end
	end

endmodule

// ==== verif/board_io_tb.sv ====
// Testbench top for the board I/O peripheral
// Clock, reset, LFSR write data, operations from the stimulus file, watchdog, result
`timescale 1ns/1ps

module board_io_tb;

	logic clk50;
	logic core_reset;
	logic io_write_en;
	logic io_read_en;
	logic [board_io_pkg::addr_w-1:0] io_address;
	logic [board_io_pkg::data_w-1:0] io_write_data;
	logic [board_io_pkg::data_w-1:0] io_read_data;
	logic [board_io_pkg::red_w-1:0] red_led;
	logic [board_io_pkg::green_w-1:0] green_led;
	logic [board_io_pkg::hex_w-1:0] hex0, hex1, hex2, hex3;
	logic uart_line;	// TX looped back to RX

	logic chk_read, chk_below, chk_mark, chk_delta, chk_display, chk_line_idle;
	logic wait_timeout, test_done, run_done;	// Requests to the checker
	logic [31:0] exp_addr, exp_value, exp_mask;
	int test_num;
	int error_count, tests_passed, tests_failed;

	logic [31:0] op_code[$], op_addr[$], op_data[$], op_exp[$];	// One entry per file line
	logic [31:0] lfsr_state;
	bit ops_loaded;
	int reset_cycles = 16;
	int frame_cycles = (board_io_pkg::uart_bits + 2) * board_io_pkg::baud_divide;	// Start, data, stop

	board_io_top dut
	(
		.clk50(clk50), .core_reset(core_reset), .io_write_en(io_write_en),
		.io_read_en(io_read_en), .io_address(io_address), .io_write_data(io_write_data),
		.io_read_data(io_read_data), .red_led(red_led), .green_led(green_led),
		.hex0(hex0), .hex1(hex1), .hex2(hex2), .hex3(hex3),
		.uart_tx(uart_line), .uart_rx(uart_line)
	);

	board_io_checker monitor
	(
		.clk50(clk50), .core_reset(core_reset), .io_read_data(io_read_data),
		.red_led(red_led), .green_led(green_led), .hex0(hex0), .hex1(hex1), .hex2(hex2),
		.hex3(hex3), .uart_tx(uart_line), .chk_read(chk_read), .chk_below(chk_below),
		.chk_mark(chk_mark), .chk_delta(chk_delta), .chk_display(chk_display),
		.chk_line_idle(chk_line_idle), .wait_timeout(wait_timeout), .test_done(test_done),
		.run_done(run_done), .test_num(test_num), .exp_addr(exp_addr), .exp_value(exp_value),
		.exp_mask(exp_mask), .error_count(error_count), .tests_passed(tests_passed),
		.tests_failed(tests_failed)
	);

	bind uart_port board_io_props uart_props
	(
		.clk50(clk50), .core_reset(core_reset), .tx_state(tx_state), .rx_state(rx_state),
		.uart_tx(uart_tx), .rx_avail(rx_avail), .sel(board_io_pkg::sel_red), .io_read_data('0)
	);

	bind timer_readback board_io_props readback_props
	(
		.clk50(clk50), .core_reset(core_reset), .tx_state(board_io_pkg::st_idle),
		.rx_state(board_io_pkg::st_idle), .uart_tx(1'b1), .rx_avail(1'b0),
		.sel(bus.sel), .io_read_data(io_read_data)
	);

	initial
	begin
		clk50 = 1'b0;
		forever #4 clk50 = ~clk50;	// 125 MHz sim clock
	end

	// x^32 + x^22 + x^2 + x + 1, one step per bit
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic draw_random(output logic [31:0] value);
		value = '0;
		for (int b = 0; b < 32; b++)
		begin
			lfsr_state = lfsr_next(lfsr_state);
			value = {value[30:0], lfsr_state[0]};
		end
	endtask

	task automatic load_ops;
		int fd;
		string line;
		logic [31:0] f_op, f_addr, f_data, f_exp;
		fd = $fopen("verif/board_io_stim.txt", "r");
		if (fd == 0)
			$display("Could not open verif/board_io_stim.txt, no operations to run");
		else
		begin
			while (!$feof(fd))
			begin
				line = "";
				void'($fgets(line, fd));
				if ($sscanf(line, "%h %h %h %h", f_op, f_addr, f_data, f_exp) == 4)
				begin
					op_code.push_back(f_op);
					op_addr.push_back(f_addr);
					op_data.push_back(f_data);
					op_exp.push_back(f_exp);
				end
			end
			$fclose(fd);
		end
		ops_loaded = 1'b1;
	endtask

	task automatic idle_strobes;
		io_write_en <= 1'b0;
		io_read_en <= 1'b0;
		{chk_read, chk_below, chk_mark, chk_delta, chk_display, chk_line_idle} <= '0;
		{wait_timeout, test_done, run_done} <= '0;
	endtask

	// Poll a status bit, address already on the status register
	task automatic wait_status(input int bit_idx, input int busy_until, inout int elapsed);
		int cycles;
		bit seen;
		cycles = 0;
		seen = 1'b0;
		while (!seen && cycles < 300)
		begin
			@(posedge clk50);
			cycles++;
			elapsed++;	// Cycles since the frame started
			seen = io_read_data[bit_idx];
			chk_read <= (elapsed < busy_until);	// TX busy compare
		end
		if (!seen)
			wait_timeout <= 1'b1;
	endtask

	task automatic uart_loopback(input logic [31:0] data, input logic [31:0] want,
		input bit second_write);
		int elapsed;
		elapsed = 0;
		io_write_en <= 1'b1;
		io_address <= board_io_pkg::addr_uart_data;
		io_write_data <= {24'h0, data[7:0]};
		@(posedge clk50);
		idle_strobes();
		if (second_write)
		begin
			repeat (4) @(posedge clk50);
			io_write_en <= 1'b1;	// Lands mid start bit
			io_write_data <= {24'h0, data[15:8]};
			@(posedge clk50);
			idle_strobes();
		end
		else
		begin
			exp_mask <= 32'h1;
			exp_value <= 32'h0;
			chk_read <= 1'b1;
		end
		io_address <= board_io_pkg::addr_uart_status;
		wait_status(1, second_write ? 0 : frame_cycles, elapsed);	// Byte available
		wait_status(0, second_write ? 0 : frame_cycles, elapsed);	// Frame finished
		@(posedge clk50);
		idle_strobes();
		io_address <= board_io_pkg::addr_uart_data;
		exp_mask <= '1;
		exp_value <= want;
		chk_read <= 1'b1;
		test_done <= 1'b1;
	endtask

	task automatic run_op(input int idx);
		logic [31:0] wdata;
		logic [31:0] want;
		case (op_code[idx])
			0:	// Post-reset display and line state
			begin
				chk_display <= 1'b1;
				chk_line_idle <= 1'b1;
				exp_addr <= op_addr[idx];
				test_done <= 1'b1;
			end
			1, 2:
			begin
				wdata = op_data[idx];
				want = op_exp[idx];
				if (op_code[idx] == 2)
				begin
					draw_random(wdata);
					want = wdata & op_exp[idx];	// Exp column holds the mask
				end
				io_write_en <= 1'b1;
				io_address <= op_addr[idx];
				io_write_data <= wdata;
				@(posedge clk50);
				idle_strobes();
				chk_display <= 1'b1;
				exp_addr <= op_addr[idx];
				exp_value <= want;
				test_done <= 1'b1;
			end
			3, 4:
			begin
				io_address <= op_addr[idx];
				exp_mask <= op_data[idx];
				exp_value <= op_exp[idx];
				chk_read <= op_code[idx] == 3;
				chk_below <= op_code[idx] == 4;
				test_done <= 1'b1;
			end
			5:	// Two timer reads N cycles apart
			begin
				io_address <= op_addr[idx];
				chk_mark <= 1'b1;
				@(posedge clk50);
				idle_strobes();
				repeat (op_data[idx] - 1) @(posedge clk50);
				chk_delta <= 1'b1;
				exp_value <= op_exp[idx];
				test_done <= 1'b1;
			end
			6, 7: uart_loopback(op_data[idx], op_exp[idx], op_code[idx] == 7);
			8:	// Read strobe on data, then status
			begin
				io_address <= op_addr[idx];
				io_read_en <= 1'b1;
				@(posedge clk50);
				idle_strobes();
				io_address <= board_io_pkg::addr_uart_status;
				exp_mask <= op_data[idx];
				exp_value <= op_exp[idx];
				chk_read <= 1'b1;
				test_done <= 1'b1;
			end
			default: $display("Unknown operation %0h on stimulus line %0d", op_code[idx], idx);
		endcase
	endtask

	initial
	begin
		core_reset <= 1'b1;
		io_address <= '0;
		io_write_data <= '0;
		idle_strobes();
		{exp_addr, exp_value, exp_mask} <= '0;
		test_num <= 0;
		lfsr_state = 32'hee816016;
		load_ops();
		repeat (reset_cycles) @(posedge clk50);
		core_reset <= 1'b0;
		for (int i = 0; i < op_code.size(); i++)
		begin
			@(posedge clk50);
			idle_strobes();
			test_num <= i;
			run_op(i);
		end
		@(posedge clk50);
		idle_strobes();
		run_done <= 1'b1;	// Checker prints counts
		@(posedge clk50);
		idle_strobes();
		@(posedge clk50);
		if (op_code.size() > 0 && tests_passed == op_code.size() && error_count == 0
			&& dut.uart.uart_props.fail_count == 0
			&& dut.readback.readback_props.fail_count == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

	// Budget of 400 cycles per operation plus reset and tail
	initial
	begin
		wait (ops_loaded);
		repeat (reset_cycles + op_code.size() * 400 + 32) @(posedge clk50);
		$display("Watchdog expired at %0t, the operations did not finish in time", $time);
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// ==== verif/board_io_stim.txt ====
# Columns, all hex: op address data expected
# op 0 idle check, 1 write, 2 random write (expected = mask), 3 read (data = mask)
# op 4 read below expected, 5 timer step (data = cycles), 6 UART loopback
# op 7 UART with busy second write (data = second:first), 8 read strobe clear (data = mask)
0 00000020 00000000 00000000
3 00000018 ffffffff 00000001
4 00000024 00000000 00000040
1 00000000 fff3a5c7 0003a5c7
1 00000004 12345abc 000000bc
1 00000008 0000ff5d 0000005d
1 0000000c 00000123 00000023
2 00000010 00000000 0000007f
2 00000014 00000000 0000007f
2 00000000 00000000 0003ffff
1 00000020 ffffffff 00000000
1 00000006 ffffffff 00000000
3 00000000 ffffffff 00000000
3 00000020 ffffffff 00000000
5 00000024 00000064 00000064
6 0000001c 000000a5 000000a5
8 0000001c 00000002 00000000
7 0000001c 00003c5a 0000005a
8 0000001c 00000002 00000000

// ==== compile.f ====
hdl/board_io_pkg.sv
hdl/io_bus_if.sv
hdl/io_addr_decode.sv
hdl/display_regs.sv
hdl/uart_port.sv
hdl/timer_readback.sv
hdl/board_io_top.sv
verif/board_io_props.sv
verif/board_io_checker.sv
verif/board_io_tb.sv

// ==== Bender.yml ====
package:
  name: board_io

sources:
  - hdl/board_io_pkg.sv
  - hdl/io_bus_if.sv
  - hdl/io_addr_decode.sv
  - hdl/display_regs.sv
  - hdl/uart_port.sv
  - hdl/timer_readback.sv
  - hdl/board_io_top.sv
  - target: test
    files:
      - verif/board_io_props.sv
      - verif/board_io_checker.sv
      - verif/board_io_tb.sv
